// File: source/alu_exec_pkg.sv
// ALU slice shared definitions
package alu_exec_pkg;

    // Datapath and station sizing
    localparam int XLEN       = 64;
    localparam int RS_DEPTH   = 8;
    localparam int RS_IDX_LEN = $clog2(RS_DEPTH);
    localparam int TAG_LEN    = 4;
    localparam int CTL_LEN    = 4;
    localparam int EXCEPT_LEN = 2;
    // Shift amount taken from the low bits of rs2
    localparam int SHAMT_LEN  = $clog2(XLEN);

    // ALU control codes, anything from 8 upward is illegal
    typedef enum logic [CTL_LEN-1:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7
    } alu_op_e;

    // Exception codes reported with a result
    typedef enum logic [EXCEPT_LEN-1:0] {
        EXC_NONE       = 2'd0,
        EXC_ILLEGAL_OP = 2'd1
    } except_e;

    // Source operand, either a value or the tag it waits for
    typedef struct packed {
        logic               ready;
        logic [TAG_LEN-1:0] tag;
        logic [XLEN-1:0]    value;
    } operand_t;

    // Micro-op on the issue port, also the station entry payload
    typedef struct packed {
        logic [CTL_LEN-1:0] ctl;
        logic [TAG_LEN-1:0] dest_tag;
        operand_t           rs1;
        operand_t           rs2;
    } issue_req_t;

    // Dispatch request towards the execution unit
    typedef struct packed {
        logic [CTL_LEN-1:0]    ctl;
        logic [RS_IDX_LEN-1:0] idx;
        logic [XLEN-1:0]       rs1_value;
        logic [XLEN-1:0]       rs2_value;
    } eu_req_t;

    // Execution unit response, tagged by station entry
    typedef struct packed {
        logic [RS_IDX_LEN-1:0] idx;
        logic [XLEN-1:0]       result;
        logic                  except_raised;
        except_e               except_code;
    } eu_resp_t;

    // Result broadcast on the common data bus
    typedef struct packed {
        logic [TAG_LEN-1:0] tag;
        logic [XLEN-1:0]    result;
        logic               except_raised;
        except_e            except_code;
    } cdb_t;

endpackage

// File: source/alu_eu.sv
// ALU execution unit
`timescale 1ns/100ps

module alu_eu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // Request from the station
    input  logic                   eu_valid_i,
    output logic                   eu_ready_o,
    input  alu_exec_pkg::eu_req_t  eu_req_i,
    // Response towards the station
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output alu_exec_pkg::eu_resp_t eu_resp_o
);

    logic [alu_exec_pkg::XLEN-1:0]      result_d;
    logic                               illegal_d;
    logic [alu_exec_pkg::SHAMT_LEN-1:0] shamt;
    logic                               req_fire;
    logic                               resp_valid_q;
    alu_exec_pkg::eu_resp_t             resp_q;

    assign shamt = eu_req_i.rs2_value[alu_exec_pkg::SHAMT_LEN-1:0];

    // Operation decode
    always_comb begin
        result_d  = '0;
        illegal_d = 1'b0;
        case (eu_req_i.ctl)
            alu_exec_pkg::ALU_ADD: result_d = eu_req_i.rs1_value + eu_req_i.rs2_value;
            alu_exec_pkg::ALU_SUB: result_d = eu_req_i.rs1_value - eu_req_i.rs2_value;
            alu_exec_pkg::ALU_AND: result_d = eu_req_i.rs1_value & eu_req_i.rs2_value;
            alu_exec_pkg::ALU_OR:  result_d = eu_req_i.rs1_value | eu_req_i.rs2_value;
            alu_exec_pkg::ALU_XOR: result_d = eu_req_i.rs1_value ^ eu_req_i.rs2_value;
            alu_exec_pkg::ALU_SLL: result_d = eu_req_i.rs1_value << shamt;
            alu_exec_pkg::ALU_SRL: result_d = eu_req_i.rs1_value >> shamt;
            alu_exec_pkg::ALU_SLT: begin
                // Signed compare, result is 1 or 0
                result_d = {{(alu_exec_pkg::XLEN-1){1'b0}},
                            ($signed(eu_req_i.rs1_value) < $signed(eu_req_i.rs2_value))};
            end
            // Unknown code gives zero and an exception
            default: illegal_d = 1'b1;
        endcase
    end

    // Free, or draining this cycle
    assign eu_ready_o = !resp_valid_q || resp_ready_i;
    assign req_fire   = eu_valid_i && eu_ready_o;

    // Result valid flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_valid_q <= 1'b0;
        end else if (flush_i) begin
            resp_valid_q <= 1'b0;
        end else if (req_fire) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    // Result payload, held while back-pressured
    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            resp_q <= '0;
        end else if (req_fire) begin
            resp_q.idx           <= eu_req_i.idx;
            resp_q.result        <= result_d;
            resp_q.except_raised <= illegal_d;
            resp_q.except_code   <= illegal_d ? alu_exec_pkg::EXC_ILLEGAL_OP
                                              : alu_exec_pkg::EXC_NONE;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign eu_resp_o    = resp_q;

endmodule

// File: source/alu_rs.sv
// ALU reservation station
`timescale 1ns/100ps

module alu_rs (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    // Issue port
    input  logic                    issue_valid_i,
    input  alu_exec_pkg::issue_req_t issue_i,
    output logic                    issue_ready_o,
    // Dispatch to the execution unit
    output logic                    eu_valid_o,
    input  logic                    eu_ready_i,
    output alu_exec_pkg::eu_req_t   eu_req_o,
    // Response from the execution unit
    input  logic                    resp_valid_i,
    output logic                    resp_ready_o,
    input  alu_exec_pkg::eu_resp_t  eu_resp_i,
    // Common data bus
    output logic                    cdb_valid_o,
    output alu_exec_pkg::cdb_t      cdb_o,
    input  logic                    cdb_ready_i
);

    // Entry state, control bits reset, payload does not
    logic [alu_exec_pkg::RS_DEPTH-1:0] valid_q;
    logic [alu_exec_pkg::RS_DEPTH-1:0] busy_q;
    alu_exec_pkg::issue_req_t          entry_q [alu_exec_pkg::RS_DEPTH];

    logic [alu_exec_pkg::RS_DEPTH-1:0]   eligible;
    logic                                free_found;
    logic [alu_exec_pkg::RS_IDX_LEN-1:0] free_idx;
    logic                                disp_found;
    logic [alu_exec_pkg::RS_IDX_LEN-1:0] disp_idx;
    logic                                issue_fire;
    logic                                disp_fire;
    logic                                cdb_fire;
    alu_exec_pkg::issue_req_t            issue_wk;

    // Capture the broadcast value if the operand waits on its tag
    function automatic alu_exec_pkg::operand_t wake_operand(
        input alu_exec_pkg::operand_t op,
        input logic                   fire,
        input alu_exec_pkg::cdb_t     cdb
    );
        alu_exec_pkg::operand_t res;
        res = op;
        if (fire && !op.ready && (op.tag == cdb.tag)) begin
            res.ready = 1'b1;
            res.value = cdb.result;
        end
        return res;
    endfunction

    // Lowest free entry takes the next micro-op
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < alu_exec_pkg::RS_DEPTH; i++) begin
            if (!valid_q[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = alu_exec_pkg::RS_IDX_LEN'(i);
            end
        end
    end

    // Eligible when both operands are ready and not yet dispatched
    always_comb begin
        disp_found = 1'b0;
        disp_idx   = '0;
        for (int i = 0; i < alu_exec_pkg::RS_DEPTH; i++) begin
            eligible[i] = valid_q[i] && !busy_q[i] &&
                          entry_q[i].rs1.ready && entry_q[i].rs2.ready;
            // Lowest index wins
            if (eligible[i] && !disp_found) begin
                disp_found = 1'b1;
                disp_idx   = alu_exec_pkg::RS_IDX_LEN'(i);
            end
        end
    end

    // Handshakes
    assign issue_ready_o = free_found && !flush_i;
    assign issue_fire    = issue_valid_i && issue_ready_o;
    assign eu_valid_o    = disp_found;
    assign disp_fire     = eu_valid_o && eu_ready_i;
    assign resp_ready_o  = cdb_ready_i;
    assign cdb_valid_o   = resp_valid_i;
    assign cdb_fire      = cdb_valid_o && cdb_ready_i;

    // Request for the selected entry
    always_comb begin
        eu_req_o.ctl       = entry_q[disp_idx].ctl;
        eu_req_o.idx       = disp_idx;
        eu_req_o.rs1_value = entry_q[disp_idx].rs1.value;
        eu_req_o.rs2_value = entry_q[disp_idx].rs2.value;
    end

    // Broadcast uses the dest tag of the returning entry
    always_comb begin
        cdb_o.tag           = entry_q[eu_resp_i.idx].dest_tag;
        cdb_o.result        = eu_resp_i.result;
        cdb_o.except_raised = eu_resp_i.except_raised;
        cdb_o.except_code   = eu_resp_i.except_code;
    end

    // Incoming operands also see the broadcast of this cycle
    always_comb begin
        issue_wk     = issue_i;
        issue_wk.rs1 = wake_operand(issue_i.rs1, cdb_fire, cdb_o);
        issue_wk.rs2 = wake_operand(issue_i.rs2, cdb_fire, cdb_o);
    end

    // Entry payload and operand wake-up
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < alu_exec_pkg::RS_DEPTH; i++) begin
            if (issue_fire && (free_idx == alu_exec_pkg::RS_IDX_LEN'(i))) begin
                entry_q[i] <= issue_wk;
            end else if (valid_q[i]) begin
                entry_q[i].rs1 <= wake_operand(entry_q[i].rs1, cdb_fire, cdb_o);
                entry_q[i].rs2 <= wake_operand(entry_q[i].rs2, cdb_fire, cdb_o);
            end
        end
    end

    // Allocation, dispatch marking and release
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            busy_q  <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            busy_q  <= '0;
        end else begin
            for (int i = 0; i < alu_exec_pkg::RS_DEPTH; i++) begin
                if (issue_fire && (free_idx == alu_exec_pkg::RS_IDX_LEN'(i))) begin
                    valid_q[i] <= 1'b1;
                    busy_q[i]  <= 1'b0;
                end
                // Dispatched entries wait for their broadcast
                if (disp_fire && (disp_idx == alu_exec_pkg::RS_IDX_LEN'(i))) begin
                    busy_q[i] <= 1'b1;
                end
                // Freed once the result leaves on the bus
                if (cdb_fire && (eu_resp_i.idx == alu_exec_pkg::RS_IDX_LEN'(i))) begin
                    valid_q[i] <= 1'b0;
                    busy_q[i]  <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/alu_exec_top.sv
// ALU execution slice top
`timescale 1ns/100ps

module alu_exec_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     issue_valid_i,
    input  alu_exec_pkg::issue_req_t issue_i,
    output logic                     issue_ready_o,
    output logic                     cdb_valid_o,
    output alu_exec_pkg::cdb_t       cdb_o,
    input  logic                     cdb_ready_i
);

    // Dispatch channel
    logic                   eu_valid;
    logic                   eu_ready;
    alu_exec_pkg::eu_req_t  eu_req;
    // Response channel
    logic                   resp_valid;
    logic                   resp_ready;
    alu_exec_pkg::eu_resp_t eu_resp;

    alu_rs u_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .eu_valid_o    (eu_valid),
        .eu_ready_i    (eu_ready),
        .eu_req_o      (eu_req),
        .resp_valid_i  (resp_valid),
        .resp_ready_o  (resp_ready),
        .eu_resp_i     (eu_resp),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_o         (cdb_o),
        .cdb_ready_i   (cdb_ready_i)
    );

    alu_eu u_eu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .eu_valid_i   (eu_valid),
        .eu_ready_o   (eu_ready),
        .eu_req_i     (eu_req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .eu_resp_o    (eu_resp)
    );

endmodule

// File: dv/alu_exec_vectors.svh
// ALU slice stimulus table
// Columns: ctl, dest tag, rs1 is a tag, rs1 value or tag, rs2 is a tag, rs2 value or tag
// Second line of a row: expected result, expected exception raised

typedef struct packed {
    logic [alu_exec_pkg::CTL_LEN-1:0] ctl;
    logic [alu_exec_pkg::TAG_LEN-1:0] dest;
    logic                             rs1_is_tag;
    logic [alu_exec_pkg::XLEN-1:0]    rs1;
    logic                             rs2_is_tag;
    logic [alu_exec_pkg::XLEN-1:0]    rs2;
    logic [alu_exec_pkg::XLEN-1:0]    exp_result;
    logic                             exp_raised;
} vec_t;

localparam int NUM_VECS = 14;

localparam vec_t VECTORS [NUM_VECS] = '{
    // Independent rows, one per operation
    '{alu_exec_pkg::ALU_ADD, 4'd0, 1'b0, 64'h0000_0000_FFFF_FFFF, 1'b0, 64'h1,
      64'h0000_0001_0000_0000, 1'b0},
    '{alu_exec_pkg::ALU_SUB, 4'd1, 1'b0, 64'h5, 1'b0, 64'h7,
      64'hFFFF_FFFF_FFFF_FFFE, 1'b0},
    '{alu_exec_pkg::ALU_AND, 4'd2, 1'b0, 64'hF0F0_F0F0_F0F0_F0F0, 1'b0, 64'hFF00_FF00_FF00_FF00,
      64'hF000_F000_F000_F000, 1'b0},
    '{alu_exec_pkg::ALU_OR, 4'd3, 1'b0, 64'h1234_0000_0000_0000, 1'b0, 64'h5678,
      64'h1234_0000_0000_5678, 1'b0},
    '{alu_exec_pkg::ALU_XOR, 4'd4, 1'b0, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0, 64'hFFFF_0000_FFFF_0000,
      64'h5555_AAAA_5555_AAAA, 1'b0},
    // Only the low six bits of 0x44 count
    '{alu_exec_pkg::ALU_SLL, 4'd5, 1'b0, 64'h1, 1'b0, 64'h44,
      64'h10, 1'b0},
    '{alu_exec_pkg::ALU_SRL, 4'd6, 1'b0, 64'h8000_0000_0000_0000, 1'b0, 64'h3F,
      64'h1, 1'b0},
    // Signed, -1 is less than 1
    '{alu_exec_pkg::ALU_SLT, 4'd7, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 64'h1,
      64'h1, 1'b0},
    // Illegal control code
    '{4'hB, 4'd8, 1'b0, 64'h1234, 1'b0, 64'h5678,
      64'h0, 1'b1},
    // Dependent rows, operands name earlier tags
    '{alu_exec_pkg::ALU_ADD, 4'd9, 1'b1, 64'd0, 1'b1, 64'd1,
      64'h0000_0000_FFFF_FFFE, 1'b0},
    '{alu_exec_pkg::ALU_SLT, 4'd10, 1'b1, 64'd1, 1'b1, 64'd7,
      64'h1, 1'b0},
    // Chained on another dependent row
    '{alu_exec_pkg::ALU_XOR, 4'd11, 1'b1, 64'd9, 1'b0, 64'h0000_0000_FFFF_FFFF,
      64'h1, 1'b0},
    '{alu_exec_pkg::ALU_SRL, 4'd12, 1'b1, 64'd4, 1'b1, 64'd5,
      64'h0000_5555_AAAA_5555, 1'b0},
    '{alu_exec_pkg::ALU_SUB, 4'd13, 1'b1, 64'd3, 1'b0, 64'h78,
      64'h1234_0000_0000_5600, 1'b0}
};

// File: dv/alu_exec_tb.sv
// ALU slice testbench
`timescale 1ns/100ps

module alu_exec_tb;

    `include "alu_exec_vectors.svh"

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DELAY = 2;
    localparam logic [31:0] SEED        = 32'hedf53c86;
    localparam int          NUM_TAGS    = 2 ** alu_exec_pkg::TAG_LEN;
    // Table, full station, flushed rows and the fresh row after flush
    localparam int ROWS_ISSUED    = NUM_VECS + 8 + 3 + 1;
    localparam int TIMEOUT_CYCLES = ROWS_ISSUED * 20 + 100;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     flush_i;
    logic                     issue_valid_i;
    alu_exec_pkg::issue_req_t issue_i;
    logic                     issue_ready_o;
    logic                     cdb_valid_o;
    alu_exec_pkg::cdb_t       cdb_o;
    logic                     cdb_ready_i;

    // Scoreboard indexed by tag
    logic [alu_exec_pkg::XLEN-1:0] exp_result [NUM_TAGS];
    logic [NUM_TAGS-1:0]           exp_raised;
    logic [NUM_TAGS-1:0]           pending;
    logic [NUM_TAGS-1:0]           done;
    // Back-pressure mode and stall tracking
    logic                          hold_low;
    logic                          hold_prev;
    alu_exec_pkg::cdb_t            cdb_prev;

    alu_exec_top dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_o         (cdb_o),
        .cdb_ready_i   (cdb_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        end_with_failure();
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic next_drive();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    // Operand as the register file would supply it
    function automatic alu_exec_pkg::operand_t make_operand(input logic is_tag,
                                                            input logic [63:0] src);
        alu_exec_pkg::operand_t           op;
        logic [alu_exec_pkg::TAG_LEN-1:0] tag;
        tag = src[alu_exec_pkg::TAG_LEN-1:0];
        op  = '0;
        if (!is_tag) begin
            op.ready = 1'b1;
            op.value = src;
        end else if (done[tag]) begin
            // Producer already broadcast
            op.ready = 1'b1;
            op.value = exp_result[tag];
        end else begin
            op.tag = tag;
        end
        return op;
    endfunction

    // Operands are rebuilt every cycle the issue port stalls
    task automatic issue_row(input int row);
        vec_t v;
        logic accepted;
        v                  = VECTORS[row];
        exp_result[v.dest] = v.exp_result;
        exp_raised[v.dest] = v.exp_raised;
        pending[v.dest]    = 1'b1;
        done[v.dest]       = 1'b0;
        accepted           = 1'b0;
        issue_valid_i      = 1'b1;
        while (!accepted) begin
            issue_i.ctl      = v.ctl;
            issue_i.dest_tag = v.dest;
            issue_i.rs1      = make_operand(v.rs1_is_tag, v.rs1);
            issue_i.rs2      = make_operand(v.rs2_is_tag, v.rs2);
            @(negedge clk_i);
            accepted = issue_ready_o;
            next_drive();
        end
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (pending != '0) begin
            next_drive();
        end
    endtask

    // Random or held-low back-pressure with the mode sampled at the edge
    initial begin
        logic mode;
        void'($urandom(SEED));
        forever begin
            @(posedge clk_i);
            mode = hold_low;
            #DRIVE_DELAY;
            cdb_ready_i = mode ? 1'b0 : (($urandom() % 4) != 0);
        end
    end

    // Broadcast checker ahead of the transfer edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            // Stalled broadcast must hold steady
            if (hold_prev) begin
                check_value("cdb_valid_o", 64'(cdb_valid_o), 64'h1);
                check_value("cdb_o.tag", 64'(cdb_o.tag), 64'(cdb_prev.tag));
                check_value("cdb_o.result", cdb_o.result, cdb_prev.result);
                check_value("cdb_o.except_raised", 64'(cdb_o.except_raised),
                            64'(cdb_prev.except_raised));
                check_value("cdb_o.except_code", 64'(cdb_o.except_code),
                            64'(cdb_prev.except_code));
            end
            if (cdb_valid_o && cdb_ready_i) begin
                if (!pending[cdb_o.tag]) begin
                    abort_run($sformatf("Broadcast of tag %0d that was not expected",
                                        cdb_o.tag));
                end
                check_value("cdb_o.result", cdb_o.result, exp_result[cdb_o.tag]);
                check_value("cdb_o.except_raised", 64'(cdb_o.except_raised),
                            64'(exp_raised[cdb_o.tag]));
                check_value("cdb_o.except_code", 64'(cdb_o.except_code),
                            exp_raised[cdb_o.tag] ? 64'(alu_exec_pkg::EXC_ILLEGAL_OP)
                                                  : 64'(alu_exec_pkg::EXC_NONE));
                pending[cdb_o.tag] = 1'b0;
                done[cdb_o.tag]    = 1'b1;
            end
            hold_prev = cdb_valid_o && !cdb_ready_i && !flush_i;
            cdb_prev  = cdb_o;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired, the run hung");
    end

    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cdb_ready_i   = 1'b0;
        hold_low      = 1'b0;
        hold_prev     = 1'b0;
        cdb_prev      = '0;
        pending       = '0;
        done          = '0;
        exp_raised    = '0;
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("cdb_valid_o", 64'(cdb_valid_o), 64'h0);
        check_value("issue_ready_o", 64'(issue_ready_o), 64'h1);
        next_drive();

        // Whole table under random back-pressure
        for (int r = 0; r < NUM_VECS; r++) begin
            issue_row(r);
        end
        wait_drained();

        // Fill all eight entries with the bus stalled
        hold_low = 1'b1;
        for (int r = 0; r < 8; r++) begin
            issue_row(r);
        end
        @(negedge clk_i);
        check_value("issue_ready_o", 64'(issue_ready_o), 64'h0);
        next_drive();
        hold_low = 1'b0;
        wait_drained();

        // Flush work that never reached the bus
        hold_low = 1'b1;
        for (int r = 0; r < 3; r++) begin
            issue_row(r);
        end
        repeat (3) next_drive();
        flush_i = 1'b1;
        next_drive();
        flush_i  = 1'b0;
        pending  = '0;
        hold_low = 1'b0;
        @(negedge clk_i);
        check_value("cdb_valid_o", 64'(cdb_valid_o), 64'h0);
        check_value("issue_ready_o", 64'(issue_ready_o), 64'h1);
        repeat (8) next_drive();
        issue_row(3);
        wait_drained();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: compile.f
+incdir+dv
source/alu_exec_pkg.sv
source/alu_eu.sv
source/alu_rs.sv
source/alu_exec_top.sv
dv/alu_exec_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ALU slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module alu_exec_tb -f compile.f -o alu_exec_sim

# The simulator exits non-zero on a fatal error, the log decides
./obj_dir/alu_exec_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    exit 1
fi
